// ==== mem_pkg.sv ====
package mem_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // data cache address split
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;

    localparam int STRB_W = 4;

    // kseg1 is 0xa000_0000..0xbfff_ffff, uncached
    localparam int             SEG_W     = 3;
    localparam logic [SEG_W-1:0] KSEG1_TOP = 3'b101;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LBU,
        MEM_LH,
        MEM_LHU,
        MEM_LW,
        MEM_LWL,
        MEM_LWR,
        MEM_SB,
        MEM_SH,
        MEM_SW,
        MEM_SWL,
        MEM_SWR
    } mem_op_e;

    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5
    } exc_code_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } acc_size_e;

    function automatic logic op_is_store(input mem_op_e op);
        return op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SWL, MEM_SWR};
    endfunction

    function automatic logic op_is_mem(input mem_op_e op);
        return op != MEM_NONE;
    endfunction

endpackage

// ==== mem_op_if.sv ====
`timescale 1ns/1ps

interface mem_op_if import mem_pkg::*; ();

    logic                  valid;
    logic                  allowin;
    mem_op_e               op;
    logic [XLEN-1:0]       vaddr;     // raw virtual address
    logic [TAG_W-1:0]      tag;
    logic [INDEX_W-1:0]    index;
    logic [OFFSET_W-1:0]   offset;
    logic                  uncache;
    logic [XLEN-1:0]       rt_value;
    logic [REG_ADDR_W-1:0] dest;
    logic [XLEN-1:0]       pc;
    exc_code_e             exc;

    modport src (
        output valid, op, vaddr, tag, index, offset, uncache, rt_value, dest, pc, exc,
        input  allowin
    );

    modport dst (
        input  valid, op, vaddr, tag, index, offset, uncache, rt_value, dest, pc, exc,
        output allowin
    );

endinterface

// ==== mem_addr_stage.sv ====
`timescale 1ns/1ps

module mem_addr_stage import mem_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_allowin,
    input  mem_op_e               in_op,
    input  logic [XLEN-1:0]       in_addr,
    input  logic [XLEN-1:0]       in_rt_value,
    input  logic [XLEN-1:0]       in_pc,
    input  logic [REG_ADDR_W-1:0] in_dest,
    input  logic                  flush,
    mem_op_if.src                 out
);

    logic                  as_valid;
    mem_op_e               as_op;
    logic [XLEN-1:0]       as_addr;
    logic [XLEN-1:0]       as_rt_value;
    logic [XLEN-1:0]       as_pc;
    logic [REG_ADDR_W-1:0] as_dest;

    logic            half_op;
    logic            word_op;
    logic            misalign;
    logic [XLEN-1:0] va_eff;
    logic [XLEN-1:0] paddr;

    // nothing enters while the request stage is throwing an exception
    assign in_allowin = !flush && (!as_valid || out.allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            as_valid <= 1'b0;
        end else if (flush) begin
            as_valid <= 1'b0;
        end else if (in_allowin) begin
            as_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            as_op       <= in_op;
            as_addr     <= in_addr;
            as_rt_value <= in_rt_value;
            as_pc       <= in_pc;
            as_dest     <= in_dest;
        end
    end

    // lwl/lwr/swl/swr never fault
    assign half_op  = as_op inside {MEM_LH, MEM_LHU, MEM_SH};
    assign word_op  = as_op inside {MEM_LW, MEM_SW};
    assign misalign = (half_op && as_addr[0]) || (word_op && (as_addr[1:0] != 2'b00));

    always_comb begin
        if (!misalign) begin
            out.exc = EXC_NONE;
        end else if (op_is_store(as_op)) begin
            out.exc = EXC_ADES;
        end else begin
            out.exc = EXC_ADEL;
        end
    end

    // swl addresses the word, the lane table takes care of the bytes
    assign va_eff = (as_op == MEM_SWL) ? {as_addr[XLEN-1:2], 2'b00} : as_addr;

    // kseg0/kseg1 direct map
    assign paddr = {{SEG_W{1'b0}}, va_eff[XLEN-SEG_W-1:0]};

    assign out.valid    = as_valid;
    assign out.op       = as_op;
    assign out.vaddr    = as_addr;
    assign out.tag      = paddr[XLEN-1 -: TAG_W];
    assign out.index    = paddr[OFFSET_W +: INDEX_W];
    assign out.offset   = paddr[OFFSET_W-1:0];
    assign out.uncache  = (va_eff[XLEN-1 -: SEG_W] == KSEG1_TOP);
    assign out.rt_value = as_rt_value;
    assign out.dest     = as_dest;
    assign out.pc       = as_pc;

endmodule

// ==== store_lane_format.sv ====
`timescale 1ns/1ps

module store_lane_format import mem_pkg::*; (
    input  mem_op_e           op,
    input  logic [1:0]        offset,
    input  logic [XLEN-1:0]   rt_value,
    output logic [STRB_W-1:0] wstrb,
    output logic [XLEN-1:0]   wdata,
    output acc_size_e         size
);

    logic [4:0] swl_shift;
    logic [4:0] swr_shift;

    // swl shifts right by 8*(3-offset), swr shifts left by 8*offset
    assign swl_shift = {~offset, 3'b000};
    assign swr_shift = {offset, 3'b000};

    always_comb begin
        wstrb = '0;  // loads write nothing
        wdata = '0;
        case (op)
            MEM_SB: begin
                wstrb = 4'b0001 << offset;
                wdata = {4{rt_value[7:0]}};
            end
            MEM_SH: begin
                wstrb = offset[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rt_value[15:0]}};
            end
            MEM_SW: begin
                wstrb = 4'b1111;
                wdata = rt_value;
            end
            MEM_SWL: begin
                wstrb = 4'b1111 >> ~offset;   // 0001 0011 0111 1111
                wdata = rt_value >> swl_shift;
            end
            MEM_SWR: begin
                wstrb = 4'b1111 << offset;    // 1111 1110 1100 1000
                wdata = rt_value << swr_shift;
            end
            default: begin
                wstrb = '0;
                wdata = '0;
            end
        endcase
    end

    // same size table for loads and stores
    always_comb begin
        case (op)
            MEM_LH, MEM_LHU, MEM_SH: size = SIZE_HALF;
            MEM_LW, MEM_SW:          size = SIZE_WORD;
            MEM_LWL, MEM_SWL: begin
                case (offset)
                    2'd0:    size = SIZE_BYTE;
                    2'd1:    size = SIZE_HALF;
                    default: size = SIZE_WORD;
                endcase
            end
            MEM_LWR, MEM_SWR: begin
                case (offset)
                    2'd2:    size = SIZE_HALF;
                    2'd3:    size = SIZE_BYTE;
                    default: size = SIZE_WORD;
                endcase
            end
            default: size = SIZE_BYTE;  // lb lbu sb, none
        endcase
    end

endmodule

// ==== mem_req_stage.sv ====
`timescale 1ns/1ps

module mem_req_stage import mem_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    mem_op_if.dst                 in,
    output logic                  flush,
    // memory stage
    input  logic                  ms_allowin,
    output logic                  ms_valid,
    output mem_op_e               ms_op,
    output logic [1:0]            ms_offset,
    output logic [REG_ADDR_W-1:0] ms_dest,
    output logic [XLEN-1:0]       ms_pc,
    // data cache
    output logic                  dcache_valid,
    output logic                  dcache_op,
    output logic                  dcache_uncache,
    output logic [TAG_W-1:0]      dcache_tag,
    output logic [INDEX_W-1:0]    dcache_index,
    output logic [OFFSET_W-1:0]   dcache_offset,
    output acc_size_e             dcache_size,
    output logic [STRB_W-1:0]     dcache_wstrb,
    output logic [XLEN-1:0]       dcache_wdata,
    input  logic                  dcache_addr_ok,
    // exception report
    output logic                  ex_valid,
    output exc_code_e             ex_code,
    output logic [XLEN-1:0]       ex_badvaddr,
    output logic [XLEN-1:0]       ex_pc
);

    logic                  rs_valid;
    mem_op_e               rs_op;
    logic [XLEN-1:0]       rs_vaddr;
    logic [TAG_W-1:0]      rs_tag;
    logic [INDEX_W-1:0]    rs_index;
    logic [OFFSET_W-1:0]   rs_offset;
    logic                  rs_uncache;
    logic [XLEN-1:0]       rs_rt_value;
    logic [REG_ADDR_W-1:0] rs_dest;
    logic [XLEN-1:0]       rs_pc;
    exc_code_e             rs_exc;

    logic has_exc;
    logic is_mem;
    logic ready_go;

    assign has_exc  = (rs_exc != EXC_NONE);
    assign is_mem   = op_is_mem(rs_op);
    // address-ok always comes with ms_allowin high, so the item leaves in that cycle
    assign ready_go = !is_mem || has_exc || dcache_addr_ok;

    assign flush      = rs_valid && has_exc;
    assign ms_valid   = rs_valid && ready_go && !has_exc;
    assign in.allowin = !rs_valid || (ms_valid && ms_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            rs_valid <= 1'b0;
        end else if (flush) begin
            rs_valid <= 1'b0;  // excepting item is dropped here
        end else if (in.allowin) begin
            rs_valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.allowin) begin
            rs_op       <= in.op;
            rs_vaddr    <= in.vaddr;
            rs_tag      <= in.tag;
            rs_index    <= in.index;
            rs_offset   <= in.offset;
            rs_uncache  <= in.uncache;
            rs_rt_value <= in.rt_value;
            rs_dest     <= in.dest;
            rs_pc       <= in.pc;
            rs_exc      <= in.exc;
        end
    end

    // only ask when the memory stage can take the item
    assign dcache_valid   = rs_valid && is_mem && !has_exc && ms_allowin;
    assign dcache_op      = rs_valid && op_is_store(rs_op) && !has_exc;
    assign dcache_uncache = rs_uncache;
    assign dcache_tag     = rs_tag;
    assign dcache_index   = rs_index;
    assign dcache_offset  = rs_offset;

    // byte lanes come from the unaligned address
    store_lane_format lane_i (
        .op       (rs_op),
        .offset   (rs_vaddr[1:0]),
        .rt_value (rs_rt_value),
        .wstrb    (dcache_wstrb),
        .wdata    (dcache_wdata),
        .size     (dcache_size)
    );

    assign ms_op     = rs_op;
    assign ms_offset = rs_vaddr[1:0];
    assign ms_dest   = rs_dest;
    assign ms_pc     = rs_pc;

    assign ex_valid    = flush;
    assign ex_code     = rs_exc;
    assign ex_badvaddr = rs_vaddr;
    assign ex_pc       = rs_pc;

endmodule

// ==== premem_top.sv ====
`timescale 1ns/1ps

module premem_top import mem_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    // from execute
    input  logic                  in_valid,
    output logic                  in_allowin,
    input  mem_op_e               in_op,
    input  logic [XLEN-1:0]       in_addr,
    input  logic [XLEN-1:0]       in_rt_value,
    input  logic [XLEN-1:0]       in_pc,
    input  logic [REG_ADDR_W-1:0] in_dest,
    // to memory stage
    input  logic                  ms_allowin,
    output logic                  ms_valid,
    output mem_op_e               ms_op,
    output logic [1:0]            ms_offset,
    output logic [REG_ADDR_W-1:0] ms_dest,
    output logic [XLEN-1:0]       ms_pc,
    // data cache
    output logic                  dcache_valid,
    output logic                  dcache_op,
    output logic                  dcache_uncache,
    output logic [TAG_W-1:0]      dcache_tag,
    output logic [INDEX_W-1:0]    dcache_index,
    output logic [OFFSET_W-1:0]   dcache_offset,
    output acc_size_e             dcache_size,
    output logic [STRB_W-1:0]     dcache_wstrb,
    output logic [XLEN-1:0]       dcache_wdata,
    input  logic                  dcache_addr_ok,
    // exceptions
    output logic                  ex_valid,
    output exc_code_e             ex_code,
    output logic [XLEN-1:0]       ex_badvaddr,
    output logic [XLEN-1:0]       ex_pc
);

    logic flush;

    mem_op_if op_if ();

    mem_addr_stage addr_stage_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_allowin  (in_allowin),
        .in_op       (in_op),
        .in_addr     (in_addr),
        .in_rt_value (in_rt_value),
        .in_pc       (in_pc),
        .in_dest     (in_dest),
        .flush       (flush),
        .out         (op_if.src)
    );

    mem_req_stage req_stage_i (
        .clk            (clk),
        .reset          (reset),
        .in             (op_if.dst),
        .flush          (flush),
        .ms_allowin     (ms_allowin),
        .ms_valid       (ms_valid),
        .ms_op          (ms_op),
        .ms_offset      (ms_offset),
        .ms_dest        (ms_dest),
        .ms_pc          (ms_pc),
        .dcache_valid   (dcache_valid),
        .dcache_op      (dcache_op),
        .dcache_uncache (dcache_uncache),
        .dcache_tag     (dcache_tag),
        .dcache_index   (dcache_index),
        .dcache_offset  (dcache_offset),
        .dcache_size    (dcache_size),
        .dcache_wstrb   (dcache_wstrb),
        .dcache_wdata   (dcache_wdata),
        .dcache_addr_ok (dcache_addr_ok),
        .ex_valid       (ex_valid),
        .ex_code        (ex_code),
        .ex_badvaddr    (ex_badvaddr),
        .ex_pc          (ex_pc)
    );

endmodule

// ==== tb_premem_checks.svh ====
task automatic report_mismatch(input string test, input string field,
                               input string exp, input string act);
    $display("error %s %s expected %s actual %s", test, field, exp, act);
    stop_with_failure();
endtask

task automatic check_req(
    input string                test,
    input acc_size_e            exp_size,
    input acc_size_e            act_size,
    input logic [TAG_W-1:0]     exp_tag,
    input logic [TAG_W-1:0]     act_tag,
    input logic [INDEX_W-1:0]   exp_index,
    input logic [INDEX_W-1:0]   act_index,
    input logic [OFFSET_W-1:0]  exp_offset,
    input logic [OFFSET_W-1:0]  act_offset,
    input logic                 exp_uncache,
    input logic                 act_uncache,
    input logic                 exp_store,
    input logic                 act_store,
    input logic [STRB_W-1:0]    exp_wstrb,
    input logic [STRB_W-1:0]    act_wstrb,
    input logic [XLEN-1:0]      exp_wdata,
    input logic [XLEN-1:0]      act_wdata
);
    if (act_size !== exp_size)
        report_mismatch(test, "dcache_size", exp_size.name(), act_size.name());
    if (act_tag !== exp_tag)
        report_mismatch(test, "dcache_tag", $sformatf("%h", exp_tag), $sformatf("%h", act_tag));
    if (act_index !== exp_index)
        report_mismatch(test, "dcache_index", $sformatf("%h", exp_index),
                        $sformatf("%h", act_index));
    if (act_offset !== exp_offset)
        report_mismatch(test, "dcache_offset", $sformatf("%h", exp_offset),
                        $sformatf("%h", act_offset));
    if (act_uncache !== exp_uncache)
        report_mismatch(test, "dcache_uncache", $sformatf("%b", exp_uncache),
                        $sformatf("%b", act_uncache));
    if (act_store !== exp_store)
        report_mismatch(test, "dcache_op", $sformatf("%b", exp_store), $sformatf("%b", act_store));
    if (act_wstrb !== exp_wstrb)
        report_mismatch(test, "dcache_wstrb", $sformatf("%b", exp_wstrb),
                        $sformatf("%b", act_wstrb));
    // write data only means something for stores
    if (exp_store && act_wdata !== exp_wdata)
        report_mismatch(test, "dcache_wdata", $sformatf("%h", exp_wdata),
                        $sformatf("%h", act_wdata));
endtask

task automatic check_ms(
    input string                 test,
    input mem_op_e               exp_op,
    input mem_op_e               act_op,
    input logic [1:0]            exp_offset,
    input logic [1:0]            act_offset,
    input logic [REG_ADDR_W-1:0] exp_dest,
    input logic [REG_ADDR_W-1:0] act_dest,
    input logic [XLEN-1:0]       exp_pc,
    input logic [XLEN-1:0]       act_pc
);
    if (act_op !== exp_op)
        report_mismatch(test, "ms_op", exp_op.name(), act_op.name());
    if (act_offset !== exp_offset)
        report_mismatch(test, "ms_offset", $sformatf("%h", exp_offset),
                        $sformatf("%h", act_offset));
    if (act_dest !== exp_dest)
        report_mismatch(test, "ms_dest", $sformatf("%h", exp_dest), $sformatf("%h", act_dest));
    if (act_pc !== exp_pc)
        report_mismatch(test, "ms_pc", $sformatf("%h", exp_pc), $sformatf("%h", act_pc));
endtask

task automatic check_exc(
    input string           test,
    input exc_code_e       exp_code,
    input exc_code_e       act_code,
    input logic [XLEN-1:0] exp_badvaddr,
    input logic [XLEN-1:0] act_badvaddr,
    input logic [XLEN-1:0] exp_pc,
    input logic [XLEN-1:0] act_pc
);
    if (act_code !== exp_code)
        report_mismatch(test, "ex_code", exp_code.name(), act_code.name());
    if (act_badvaddr !== exp_badvaddr)
        report_mismatch(test, "ex_badvaddr", $sformatf("%h", exp_badvaddr),
                        $sformatf("%h", act_badvaddr));
    if (act_pc !== exp_pc)
        report_mismatch(test, "ex_pc", $sformatf("%h", exp_pc), $sformatf("%h", act_pc));
endtask

// ==== tb_premem.sv ====
`timescale 1ns/1ps

module tb_premem import mem_pkg::*; ();

    localparam int MAX_LINES   = 64;
    localparam int RESET_CYCLES = 8;

    logic clk;
    logic reset;
    logic in_valid;
    logic in_allowin;
    mem_op_e in_op;
    logic [XLEN-1:0] in_addr;
    logic [XLEN-1:0] in_rt_value;
    logic [XLEN-1:0] in_pc;
    logic [REG_ADDR_W-1:0] in_dest;
    logic ms_allowin;
    logic ms_valid;
    mem_op_e ms_op;
    logic [1:0] ms_offset;
    logic [REG_ADDR_W-1:0] ms_dest;
    logic [XLEN-1:0] ms_pc;
    logic dcache_valid;
    logic dcache_op;
    logic dcache_uncache;
    logic [TAG_W-1:0] dcache_tag;
    logic [INDEX_W-1:0] dcache_index;
    logic [OFFSET_W-1:0] dcache_offset;
    acc_size_e dcache_size;
    logic [STRB_W-1:0] dcache_wstrb;
    logic [XLEN-1:0] dcache_wdata;
    logic dcache_addr_ok;
    logic ex_valid;
    exc_code_e ex_code;
    logic [XLEN-1:0] ex_badvaddr;
    logic [XLEN-1:0] ex_pc;

    // one entry per data line
    logic [3:0]            t_op[MAX_LINES];
    logic [XLEN-1:0]       t_addr[MAX_LINES];
    logic [XLEN-1:0]       t_rt[MAX_LINES];
    logic [REG_ADDR_W-1:0] t_dest[MAX_LINES];
    logic [XLEN-1:0]       t_pc[MAX_LINES];
    logic [4:0]            t_exc[MAX_LINES];
    logic                  t_unc[MAX_LINES];
    logic [TAG_W-1:0]      t_tag[MAX_LINES];
    logic [INDEX_W-1:0]    t_index[MAX_LINES];
    logic [OFFSET_W-1:0]   t_offset[MAX_LINES];
    logic [1:0]            t_size[MAX_LINES];
    logic [STRB_W-1:0]     t_wstrb[MAX_LINES];
    logic [XLEN-1:0]       t_wdata[MAX_LINES];

    int     n_lines;
    int     next_line;
    int     in_flight[$];   // accepted, oldest first
    bit     req_done;
    int     ok_wait;
    int     cycle;
    int     limit;
    integer seed = 78370;

    premem_top dut_i (.*);

    always #50 clk = ~clk;

    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1, "stopped on first failure");
    endtask

    `include "tb_premem_checks.svh"

    function automatic string test_name(input int idx);
        return $sformatf("line%0d_pc_%h", idx, t_pc[idx]);
    endfunction

    task automatic read_testdata();
        int    fd;
        int    n;
        string line;
        fd = $fopen("premem_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open premem_testdata.txt");
            stop_with_failure();
        end
        n_lines = 0;
        while ($fgets(line, fd) && n_lines < MAX_LINES) begin
            if (line.len() < 2 || line.substr(0, 0) == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                        t_op[n_lines], t_addr[n_lines], t_rt[n_lines], t_dest[n_lines],
                        t_pc[n_lines], t_exc[n_lines], t_unc[n_lines], t_tag[n_lines],
                        t_index[n_lines], t_offset[n_lines], t_size[n_lines],
                        t_wstrb[n_lines], t_wdata[n_lines]);
            if (n == 13)
                n_lines++;
        end
        $fclose(fd);
    endtask

    // looks at the outputs at the falling edge, before the next rising edge acts on them
    task automatic watch_outputs();
        int   k;
        logic exp_store;
        if (dcache_valid) begin
            if (in_flight.size() == 0) begin
                $display("a cache request appeared with no instruction in flight");
                stop_with_failure();
            end
            k = in_flight[0];
            if (t_exc[k] != 5'd0 || t_op[k] == 4'd0) begin
                $display("%s sent a cache request although it faults or is no memory op",
                         test_name(k));
                stop_with_failure();
            end
            if (req_done) begin
                $display("%s repeated its cache request after address-ok", test_name(k));
                stop_with_failure();
            end
            if (dcache_addr_ok) begin
                exp_store = mem_op_e'(t_op[k]) inside {MEM_SB, MEM_SH, MEM_SW,
                                                       MEM_SWL, MEM_SWR};
                check_req(test_name(k), acc_size_e'(t_size[k]), dcache_size,
                          t_tag[k], dcache_tag, t_index[k], dcache_index,
                          t_offset[k], dcache_offset, t_unc[k], dcache_uncache,
                          exp_store, dcache_op,
                          t_wstrb[k], dcache_wstrb, t_wdata[k], dcache_wdata);
                req_done = 1'b1;
                ok_wait  = -1;
            end
        end
        if (ex_valid) begin
            if (in_flight.size() == 0) begin
                $display("an exception was reported with no instruction in flight");
                stop_with_failure();
            end
            if (in_allowin) begin
                $display("input was open while an exception was reported");
                stop_with_failure();
            end
            k = in_flight.pop_front();
            check_exc(test_name(k), exc_code_e'(t_exc[k]), ex_code, t_addr[k], ex_badvaddr,
                      t_pc[k], ex_pc);
            in_flight.delete();   // younger items are flushed
            req_done = 1'b0;
        end
        if (ms_valid && ms_allowin) begin
            if (in_flight.size() == 0) begin
                $display("an instruction was handed on with none in flight");
                stop_with_failure();
            end
            k = in_flight.pop_front();
            if (t_exc[k] != 5'd0) begin
                $display("%s was handed on although it faults", test_name(k));
                stop_with_failure();
            end
            if ((t_op[k] != 4'd0) != req_done) begin
                $display("%s handed on with a wrong cache request count", test_name(k));
                stop_with_failure();
            end
            check_ms(test_name(k), mem_op_e'(t_op[k]), ms_op, t_addr[k][1:0], ms_offset,
                     t_dest[k], ms_dest, t_pc[k], ms_pc);
            req_done = 1'b0;
        end
        if (in_valid && in_allowin) begin
            in_flight.push_back(next_line);
            next_line++;
        end
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        in_valid       = 1'b0;
        in_op          = MEM_NONE;
        in_addr        = '0;
        in_rt_value    = '0;
        in_pc          = '0;
        in_dest        = '0;
        ms_allowin     = 1'b1;
        dcache_addr_ok = 1'b0;
        next_line      = 0;
        req_done       = 1'b0;
        ok_wait        = -1;
        cycle          = 0;
        read_testdata();
        limit = 20 * n_lines + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        if (!in_allowin || ms_valid || dcache_valid || ex_valid) begin
            $display("the handshake outputs are not idle after reset");
            stop_with_failure();
        end
        while (next_line < n_lines || in_flight.size() != 0) begin
            @(posedge clk);
            #1;
            in_valid = (next_line < n_lines);
            if (in_valid) begin
                in_op       = mem_op_e'(t_op[next_line]);
                in_addr     = t_addr[next_line];
                in_rt_value = t_rt[next_line];
                in_pc       = t_pc[next_line];
                in_dest     = t_dest[next_line];
            end
            ms_allowin = (($random(seed)) & 3) != 0;  // low about a quarter of cycles
            #1;
            if (dcache_valid && ok_wait < 0)
                ok_wait = ($random(seed)) & 3;
            dcache_addr_ok = dcache_valid && (ok_wait == 0);
            @(negedge clk);
            watch_outputs();
            if (dcache_valid && !dcache_addr_ok && ok_wait > 0)
                ok_wait--;
            cycle++;
            if (cycle > limit) begin
                $display("run timed out after %0d cycles", cycle);
                stop_with_failure();
            end
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== premem_top.f ====
mem_pkg.sv
mem_op_if.sv
mem_addr_stage.sv
store_lane_format.sv
mem_req_stage.sv
premem_top.sv
tb_premem.sv
+incdir+.

// ==== run_sim.sh ====
#!/bin/sh
# build and run the premem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f premem_top.f --top-module tb_premem -o sim_premem
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit $status
fi

./obj_dir/sim_premem
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// ==== premem_testdata.txt ====
# op addr rt_value dest pc | expected exc uncache tag index offset size wstrb wdata (all hex)
# the line after each faulting line is flushed and never checked
a 80001230 11223344 01 bfc00000 0 0 00001 23 0 2 f 11223344
5 80001230 00000000 02 bfc00004 0 0 00001 23 0 2 0 00000000
8 a0002345 deadbeef 03 bfc00008 0 1 00002 34 5 0 2 efefefef
9 80000ffe 0000cafe 04 bfc0000c 0 0 00000 ff e 1 c cafecafe
b 80003457 12345678 05 bfc00010 0 0 00003 45 4 2 f 12345678
b 80003455 12345678 06 bfc00014 0 0 00003 45 4 1 3 00001234
c 80003456 12345678 07 bfc00018 0 0 00003 45 6 1 c 56780000
c 80003457 12345678 08 bfc0001c 0 0 00003 45 7 0 8 78000000
b a0003454 12345678 09 bfc00020 0 1 00003 45 4 0 1 00000012
c a0003455 12345678 0a bfc00024 0 1 00003 45 5 2 e 34567800
0 00000000 00000000 0b bfc00028 0 0 00000 00 0 0 0 00000000
1 80004567 00000000 0c bfc0002c 0 0 00004 56 7 0 0 00000000
2 bfc00003 00000000 0d bfc00030 0 1 1fc00 00 3 0 0 00000000
3 80005672 00000000 0e bfc00034 0 0 00005 67 2 1 0 00000000
4 9000000e 00000000 0f bfc00038 0 0 10000 00 e 1 0 00000000
6 80006781 00000000 10 bfc0003c 0 0 00006 78 1 1 0 00000000
7 80006783 00000000 11 bfc00040 0 0 00006 78 3 0 0 00000000
6 80006782 00000000 12 bfc00044 0 0 00006 78 2 2 0 00000000
7 80006780 00000000 13 bfc00048 0 0 00006 78 0 2 0 00000000
3 80007001 00000000 14 bfc0004c 4 0 00007 00 1 1 0 00000000
a 80007010 55555555 15 bfc00050 0 0 00007 01 0 2 f 55555555
5 80008000 00000000 16 bfc00054 0 0 00008 00 0 2 0 00000000
9 80008003 0000beef 17 bfc00058 5 0 00008 00 3 1 c beefbeef
0 00000000 00000000 18 bfc0005c 0 0 00000 00 0 0 0 00000000
a 80009002 01020304 19 bfc00060 5 0 00009 00 2 2 f 01020304
1 80009003 00000000 1a bfc00064 0 0 00009 00 3 0 0 00000000
5 8000a001 00000000 1b bfc00068 4 0 0000a 00 1 2 0 00000000
1 8000a000 00000000 1c bfc0006c 0 0 0000a 00 0 0 0 00000000
4 8000a003 00000000 1d bfc00070 4 0 0000a 00 3 1 0 00000000
8 8000b001 000000bb 1e bfc00074 0 0 0000b 00 1 0 2 bbbbbbbb
8 a000b001 000000aa 1f bfc00078 0 1 0000b 00 1 0 2 aaaaaaaa
a a0000000 cafef00d 01 bfc0007c 0 1 00000 00 0 2 f cafef00d
9 80000100 1234abcd 02 bfc00080 0 0 00000 10 0 1 3 abcdabcd
1 80000101 00000000 03 bfc00084 0 0 00000 10 1 0 0 00000000
